// ==== rv_lite.f ====
design/rv_lite_pkg.sv
design/rv_stage_if.sv
design/rv_fetch.sv
design/rv_hazard_fsm.sv
design/rv_regbank.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lite.sv
bench/tb_clock.sv
bench/tb_rv_lite.sv

// ==== bench/tb_rv_lite.sv ====
`timescale 1ns/1ps

module tb_rv_lite
    import rv_lite_pkg::*;
();

    localparam int              PROG_LEN       = 28;
    localparam int              STORE_COUNT    = 9;
    localparam int              TIMEOUT_CYCLES = PROG_LEN * 12;
    localparam logic [XLEN-1:0] NOP_WORD       = 32'h0000_0013;

    logic            clk;
    logic            reset_i;
    logic            stall_i       = 1'b0;
    logic [XLEN-1:0] instruction_i = NOP_WORD;
    logic [XLEN-1:0] mem_data_i    = '0;
    logic [XLEN-1:0] instruction_address_o;
    logic            mem_operation_enable_o;
    logic [3:0]      mem_write_enable_o;
    logic [XLEN-1:0] mem_address_o;
    logic [XLEN-1:0] mem_data_o;

    logic [XLEN-1:0] data_mem [0:63];
    integer          seed        = 32'h3aa2;
    int              cycle_count = 0;
    int              stores_seen = 0;

    //////////////////////////////////////////////////////////////////////
    // Program and expected stores
    //////////////////////////////////////////////////////////////////////

    logic [XLEN-1:0] program_table [0:PROG_LEN-1] = '{
        32'h123450B7,  // 00 lui  x1, 0x12345
        32'h67800113,  // 04 addi x2, x0, 0x678
        32'h002081B3,  // 08 add  x3, x1, x2
        32'h08302023,  // 0c sw   x3, 0x80(x0)
        32'hFFB00213,  // 10 addi x4, x0, -5
        32'h404182B3,  // 14 sub  x5, x3, x4
        32'h0012F333,  // 18 and  x6, x5, x1
        32'h004363B3,  // 1c or   x7, x6, x4
        32'h0053C433,  // 20 xor  x8, x7, x5
        32'h000424B3,  // 24 slt  x9, x8, x0
        32'h08502223,  // 28 sw   x5, 0x84(x0)
        32'h08602423,  // 2c sw   x6, 0x88(x0)
        32'h08802623,  // 30 sw   x8, 0x8c(x0)
        32'h08902823,  // 34 sw   x9, 0x90(x0)
        32'h08702A23,  // 38 sw   x7, 0x94(x0)
        32'h04002503,  // 3c lw   x10, 0x40(x0)
        32'h01150593,  // 40 addi x11, x10, 0x11, load-use
        32'h08B02C23,  // 44 sw   x11, 0x98(x0)
        32'h00108663,  // 48 beq  x1, x1, +12 taken
        32'h0A102023,  // 4c sw   x1, 0xa0(x0) skipped
        32'h0A202223,  // 50 sw   x2, 0xa4(x0) skipped
        32'h00211463,  // 54 bne  x2, x2, +8 not taken
        32'h08202E23,  // 58 sw   x2, 0x9c(x0)
        32'h00C0066F,  // 5c jal  x12, +12
        32'h0A302423,  // 60 sw   x3, 0xa8(x0) skipped
        32'h0A402623,  // 64 sw   x4, 0xac(x0) skipped
        32'h0AC02823,  // 68 sw   x12, 0xb0(x0)
        32'h0000006F   // 6c jal  x0, 0, park here
    };

    // Address in the upper half, data in the lower half
    logic [63:0] expected_stores [0:STORE_COUNT-1] = '{
        {32'h0000_0080, 32'h1234_5678},
        {32'h0000_0084, 32'h1234_567D},
        {32'h0000_0088, 32'h1234_5000},
        {32'h0000_008C, 32'hEDCB_A986},
        {32'h0000_0090, 32'h0000_0001},
        {32'h0000_0094, 32'hFFFF_FFFB},
        {32'h0000_0098, 32'hDA7A_1021},  // Word 16 of the fill plus 0x11
        {32'h0000_009C, 32'h0000_0678},
        {32'h0000_00B0, 32'h0000_0060}   // Link of the jal at 0x5c
    };

    //////////////////////////////////////////////////////////////////////
    // Clock, DUT and memory models
    //////////////////////////////////////////////////////////////////////

    tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(3)) clock_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv_lite dut (
        .clk                    (clk),
        .reset_i                (reset_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < PROG_LEN) begin
            return program_table[idx];
        end
        return NOP_WORD;
    endfunction

    // Fill pattern over the whole word index
    initial begin
        for (int i = 0; i < 64; i++) begin
            data_mem[i] = 32'hDA7A_0000 | (i * 32'h0101);
        end
    end

    // Both memories answer one cycle after the request
    always @(posedge clk) begin
        instruction_i <= fetch_word(instruction_address_o);
        if (mem_operation_enable_o) begin
            if (mem_write_enable_o != 4'h0) begin
                data_mem[mem_address_o[7:2]] <= mem_data_o;
            end
            else begin
                mem_data_i <= data_mem[mem_address_o[7:2]];
            end
        end
    end

    // Random stall, roughly one cycle in four
    always @(posedge clk) begin
        if (reset_i) begin
            stall_i <= 1'b0;
        end
        else begin
            stall_i <= (($random(seed) & 3) == 0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_idle_outputs();
        check_value("mem_operation_enable_o", {31'b0, mem_operation_enable_o}, '0);
        check_value("instruction_address_o", instruction_address_o, RESET_PC);
    endtask

    // Reset, then walk the store table in order
    initial begin
        @(negedge clk);
        while (reset_i) begin
            check_idle_outputs();
            @(negedge clk);
        end
        // First cycle out of reset
        check_idle_outputs();

        for (int row = 0; row < STORE_COUNT; row++) begin
            @(negedge clk);
            while (!(mem_operation_enable_o && mem_write_enable_o != 4'h0)) begin
                @(negedge clk);
            end
            check_value("mem_write_enable_o", {28'b0, mem_write_enable_o}, 32'hF);
            check_value("mem_address_o", mem_address_o, expected_stores[row][63:32]);
            check_value("mem_data_o", mem_data_o, expected_stores[row][31:0]);
            stores_seen = row + 1;
        end

        // Parked on the self jump, nothing more may be written
        forever begin
            @(negedge clk);
            if (mem_operation_enable_o && mem_write_enable_o != 4'h0) begin
                $display("Unexpected store to address %h after the last expected store",
                         mem_address_o);
                $display("Simulation FAILED");
                $fatal(1, "Extra store seen");
            end
        end
    end

    // Run length limit
    always @(posedge clk) begin
        if (!reset_i) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count == TIMEOUT_CYCLES) begin
                if (stores_seen == STORE_COUNT) begin
                    $display("Simulation PASSED");
                    $finish;
                end
                else begin
                    $display("Timed out after %0d cycles with %0d of %0d stores seen",
                             cycle_count, stores_seen, STORE_COUNT);
                    $display("Simulation FAILED");
                    $fatal(1, "Timeout");
                end
            end
        end
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    // Free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset high for the first rising edges, released on an edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== design/rv_lite.sv ====
`timescale 1ns/1ps

module rv_lite
    import rv_lite_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] mem_data_i,
    output logic [XLEN-1:0] instruction_address_o,
    output logic            mem_operation_enable_o,
    output logic [3:0]      mem_write_enable_o,
    output logic [XLEN-1:0] mem_address_o,
    output logic [XLEN-1:0] mem_data_o
);

    logic                  jump;
    logic [XLEN-1:0]       jump_target;
    logic                  enable_front;
    logic                  insert_bubble;
    logic [REG_ADDR_W-1:0] rs1, rs2, load_rd;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    rv_stage_if #(.payload_t(fetch_pkt_t)) fetch_stage ();
    rv_stage_if #(.payload_t(exec_pkt_t))  decode_stage ();

    //////////////////////////////////////////////////////////////////////
    // Front end
    //////////////////////////////////////////////////////////////////////

    rv_fetch fetch1 (
        .clk                   (clk),
        .reset_i               (reset_i),
        .enable_i              (enable_front),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .fetch_o               (fetch_stage)
    );

    rv_hazard_fsm hazard1 (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .rs1_i           (rs1),
        .rs2_i           (rs2),
        .load_rd_i       (load_rd),
        .enable_front_o  (enable_front),
        .insert_bubble_o (insert_bubble)
    );

    rv_regbank regbank1 (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_en_i    (wb_en),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_decode decode1 (
        .clk             (clk),
        .reset_i         (reset_i),
        .enable_i        (enable_front),
        .insert_bubble_i (insert_bubble),
        .fetch_i         (fetch_stage),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .decode_o        (decode_stage)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute and retire
    //////////////////////////////////////////////////////////////////////

    rv_execute execute1 (
        .clk                    (clk),
        .reset_i                (reset_i),
        .stall_i                (stall_i),
        .mem_data_i             (mem_data_i),
        .decode_i               (decode_stage),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .load_rd_o              (load_rd),
        .wb_en_o                (wb_en),
        .wb_rd_o                (wb_rd),
        .wb_data_o              (wb_data),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
    import rv_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       mem_data_i,
    rv_stage_if.consumer          decode_i,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o,
    output logic [REG_ADDR_W-1:0] load_rd_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  mem_operation_enable_o,
    output logic [3:0]            mem_write_enable_o,
    output logic [XLEN-1:0]       mem_address_o,
    output logic [XLEN-1:0]       mem_data_o
);

    exec_pkt_t        pkt;
    logic [TAG_W-1:0] expected_tag;
    logic             live;
    logic [XLEN-1:0]  op_a, op_b, store_val, result;
    logic             taken, writes_rd;
    // Memory stage
    logic             m_mem_en, m_wb, m_load;
    logic [REG_ADDR_W-1:0] m_rd;
    logic [XLEN-1:0]  m_result;
    // Retire stage
    logic             r_wb, r_load, r_fresh;
    logic [REG_ADDR_W-1:0] r_rd;
    logic [XLEN-1:0]  r_result, retire_data;

    assign pkt  = decode_i.data;
    // Wrong-path packets carry an old tag
    assign live = decode_i.valid && (decode_i.tag == expected_tag);

    // Newest writer wins; loads in memory stage are covered by the bubble
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] idx,
                                                input logic [XLEN-1:0] value);
        logic [XLEN-1:0] res;
        res = value;
        if (idx != '0 && m_wb && !m_load && m_rd == idx) begin
            res = m_result;
        end
        else if (idx != '0 && r_wb && r_rd == idx) begin
            res = retire_data;
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ALU and branch resolution
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        op_a      = forward(pkt.rs1, pkt.first_operand);
        op_b      = (pkt.op == OP_STORE) ? pkt.second_operand
                                         : forward(pkt.rs2, pkt.second_operand);
        store_val = forward(pkt.rs2, pkt.store_data);
        taken     = 1'b0;
        case (pkt.op)
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_OR:   result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            OP_LUI:  result = op_b;
            default: result = op_a + op_b;
        endcase
        case (pkt.op)
            OP_BEQ:  taken = (op_a == op_b);
            OP_BNE:  taken = (op_a != op_b);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign writes_rd = live && (pkt.rd != '0)
                       && (pkt.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_SLT, OP_LUI, OP_LOAD, OP_JAL});

    assign jump_o        = live && taken && !stall_i;
    assign jump_target_o = decode_i.pc + pkt.offset;
    assign load_rd_o     = (live && pkt.op == OP_LOAD) ? pkt.rd : '0;

    //////////////////////////////////////////////////////////////////////
    // Memory request and retire registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            expected_tag       <= '0;
            m_mem_en           <= 1'b0;
            mem_write_enable_o <= '0;
            m_wb               <= 1'b0;
            r_wb               <= 1'b0;
            r_fresh            <= 1'b0;
        end
        else if (!stall_i) begin
            if (jump_o) begin
                expected_tag <= expected_tag + 1'b1;
            end
            m_mem_en           <= live && (pkt.op inside {OP_LOAD, OP_STORE});
            mem_write_enable_o <= (live && pkt.op == OP_STORE) ? 4'hF : 4'h0;
            m_wb               <= writes_rd;
            r_wb               <= m_wb;
            r_fresh            <= 1'b1;
        end
        else begin
            r_fresh <= 1'b0;
        end
    end

    // Payload, load data captured once for a stalled retire
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_address_o <= result;
            mem_data_o    <= store_val;
            m_rd          <= pkt.rd;
            m_load        <= (pkt.op == OP_LOAD);
            m_result      <= result;
            r_rd          <= m_rd;
            r_load        <= m_load;
            r_result      <= m_result;
        end
        else if (r_fresh && r_load) begin
            r_result <= mem_data_i;
        end
    end

    // Retire mux
    assign retire_data = (r_load && r_fresh) ? mem_data_i : r_result;

    assign mem_operation_enable_o = m_mem_en && !stall_i;
    assign wb_en_o                = r_wb && r_fresh;
    assign wb_rd_o                = r_rd;
    assign wb_data_o              = retire_data;

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
    import rv_lite_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   enable_i,
    input  logic                   insert_bubble_i,
    rv_stage_if.consumer           fetch_i,
    output logic [REG_ADDR_W-1:0]  rs1_o,
    output logic [REG_ADDR_W-1:0]  rs2_o,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,
    rv_stage_if.producer           decode_o
);

    fetch_pkt_t      word;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            use_rs1, use_rs2;
    exec_pkt_t       pkt;
    exec_pkt_t       pkt_r;
    logic [XLEN-1:0] pc_r;
    logic [TAG_W-1:0] tag_r;
    logic            valid_r;

    //////////////////////////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////////////////////////

    assign word   = fetch_i.data;
    assign opcode = opcode_e'(word[6:0]);
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    // Sources only for formats that read them
    assign use_rs1 = fetch_i.valid && opcode inside {OPC_OP_IMM, OPC_OP, OPC_LOAD,
                                                     OPC_STORE, OPC_BRANCH};
    assign use_rs2 = fetch_i.valid && opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

    assign rs1_o = use_rs1 ? word[19:15] : '0;
    assign rs2_o = use_rs2 ? word[24:20] : '0;

    //////////////////////////////////////////////////////////////////////
    // Operation and operand select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        pkt.op             = OP_NOP;
        pkt.rd             = '0;
        pkt.rs1            = rs1_o;
        pkt.rs2            = rs2_o;
        pkt.first_operand  = rs1_data_i;
        pkt.second_operand = rs2_data_i;
        pkt.store_data     = rs2_data_i;
        pkt.offset         = imm_b;
        case (opcode)
            OPC_LUI: begin
                pkt.op             = OP_LUI;
                pkt.rd             = word[11:7];
                pkt.second_operand = imm_u;
            end
            // ADDI only
            OPC_OP_IMM: begin
                pkt.op             = (funct3 == 3'b000) ? OP_ADD : OP_NOP;
                pkt.rd             = word[11:7];
                pkt.second_operand = imm_i;
            end
            OPC_OP: begin
                pkt.rd = word[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: pkt.op = OP_ADD;
                    {7'b0100000, 3'b000}: pkt.op = OP_SUB;
                    {7'b0000000, 3'b010}: pkt.op = OP_SLT;
                    {7'b0000000, 3'b100}: pkt.op = OP_XOR;
                    {7'b0000000, 3'b110}: pkt.op = OP_OR;
                    {7'b0000000, 3'b111}: pkt.op = OP_AND;
                    default:              pkt.op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                pkt.op             = (funct3 == 3'b010) ? OP_LOAD : OP_NOP;
                pkt.rd             = word[11:7];
                pkt.second_operand = imm_i;
            end
            OPC_STORE: begin
                pkt.op             = (funct3 == 3'b010) ? OP_STORE : OP_NOP;
                pkt.second_operand = imm_s;
            end
            OPC_BRANCH: begin
                pkt.op = (funct3 == 3'b000) ? OP_BEQ :
                         (funct3 == 3'b001) ? OP_BNE : OP_NOP;
            end
            // Link value is pc + 4
            OPC_JAL: begin
                pkt.op             = OP_JAL;
                pkt.rd             = word[11:7];
                pkt.first_operand  = fetch_i.pc;
                pkt.second_operand = 32'd4;
                pkt.offset         = imm_j;
            end
            default: pkt.op = OP_NOP;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Decode pipeline register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_r <= 1'b0;
            tag_r   <= '0;
        end
        else if (enable_i) begin
            valid_r <= fetch_i.valid;
            tag_r   <= fetch_i.tag;
        end
        else if (insert_bubble_i) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pkt_r <= pkt;
            pc_r  <= fetch_i.pc;
        end
    end

    assign decode_o.valid = valid_r;
    assign decode_o.pc    = pc_r;
    assign decode_o.tag   = tag_r;
    assign decode_o.data  = pkt_r;

endmodule

// ==== design/rv_regbank.sv ====
`timescale 1ns/1ps

module rv_regbank
    import rv_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  wb_en_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            write;

    assign write = wb_en_i && (wb_rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (write) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Read ports with write-back bypass
    assign rs1_data_o = (rs1_i == '0)                   ? '0 :
                        (write && rs1_i == wb_rd_i)     ? wb_data_i :
                                                          regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0)                   ? '0 :
                        (write && rs2_i == wb_rd_i)     ? wb_data_i :
                                                          regs[rs2_i];

endmodule

// ==== design/rv_hazard_fsm.sv ====
`timescale 1ns/1ps

module rv_hazard_fsm
    import rv_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] load_rd_i,
    output logic                  enable_front_o,
    output logic                  insert_bubble_o
);

    hazard_state_e state;
    hazard_state_e next_state;
    logic          load_use;

    // Load in execute feeding the word in decode
    assign load_use = (load_rd_i != '0)
                      && (load_rd_i == rs1_i || load_rd_i == rs2_i);

    always_comb begin
        next_state      = state;
        insert_bubble_o = 1'b0;
        case (state)
            RUN: begin
                // Bubble only on an edge that moves the load out of execute
                if (load_use && !stall_i) begin
                    insert_bubble_o = 1'b1;
                    next_state      = BUBBLE;
                end
            end
            // Load moved on; mask one cycle of detection
            BUBBLE: begin
                if (!stall_i) begin
                    next_state = RUN;
                end
            end
            default: next_state = RUN;
        endcase
    end

    assign enable_front_o = ~stall_i & ~insert_bubble_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= RUN;
        end
        else begin
            state <= next_state;
        end
    end

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch
    import rv_lite_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            enable_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_target_i,
    input  logic [XLEN-1:0] instruction_i,
    output logic [XLEN-1:0] instruction_address_o,
    rv_stage_if.producer    fetch_o
);

    logic [XLEN-1:0]  pc;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  pc_issued;
    logic [TAG_W-1:0] tag_issued;
    logic             issued;
    logic             holding;
    fetch_pkt_t       held_word;

    // PC counter, jump load and tag count
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc         <= RESET_PC;
            tag        <= '0;
            pc_issued  <= RESET_PC;
            tag_issued <= '0;
            issued     <= 1'b0;
            holding    <= 1'b0;
        end
        else begin
            if (jump_i) begin
                pc  <= jump_target_i;
                tag <= tag + 1'b1;
            end
            else if (enable_i) begin
                pc <= pc + 32'd4;
            end
            // Address just issued, aligned with the returning word
            if (jump_i || enable_i) begin
                pc_issued  <= pc;
                tag_issued <= tag;
                issued     <= 1'b1;
            end
            holding <= ~enable_i & ~jump_i;
        end
    end

    // Keep the word of a frozen cycle, memory moves on to pc
    always_ff @(posedge clk) begin
        if (!holding) begin
            held_word <= instruction_i;
        end
    end

    assign instruction_address_o = pc;

    assign fetch_o.valid = issued;
    assign fetch_o.pc    = pc_issued;
    assign fetch_o.tag   = tag_issued;
    assign fetch_o.data  = holding ? held_word : instruction_i;

endmodule

// ==== design/rv_stage_if.sv ====
`timescale 1ns/1ps

// One pipeline stage packet, level valid, no handshake
interface rv_stage_if
    import rv_lite_pkg::*;
#(
    parameter type payload_t = logic [XLEN-1:0]
) ();

    logic             valid;
    logic [XLEN-1:0]  pc;
    logic [TAG_W-1:0] tag;
    payload_t         data;

    // Upstream stage drives the packet
    modport producer (
        output valid, pc, tag, data
    );

    // Downstream stage samples it when enabled
    modport consumer (
        input valid, pc, tag, data
    );

endinterface

// ==== design/rv_lite_pkg.sv ====
package rv_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and reset values
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Major opcodes of the subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Operations seen by execute
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_LOAD,
        OP_STORE,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // Load-use controller states
    typedef enum logic {
        RUN,
        BUBBLE
    } hazard_state_e;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    // Raw instruction word from memory
    typedef logic [XLEN-1:0] fetch_pkt_t;

    // Decoded instruction with its operands
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       first_operand;
        logic [XLEN-1:0]       second_operand;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       offset;
    } exec_pkt_t;

endpackage
